/* Bender.yml */
package:
  name: cpu_core

sources:
  - include_dirs:
      - logic
    files:
      - logic/cpu_pkg.sv
      - logic/op_fetch.sv
      - logic/cpu_ctrl.sv
      - logic/reg_bank.sv
      - logic/cpu_alu.sv
      - logic/cpu_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tb/cpu_assertions.sv
      - tb/cpu_tb.sv

/* files.f */
+incdir+logic
logic/cpu_pkg.sv
logic/op_fetch.sv
logic/cpu_ctrl.sv
logic/reg_bank.sv
logic/cpu_alu.sv
logic/cpu_top.sv
tb/cpu_assertions.sv
tb/cpu_tb.sv

/* logic/cpu_alu.sv */
// move and add for the decoded command, purely combinational
// the result is cut to the operand size, reg_bank keeps the upper bits
`timescale 1ns/1ps

module cpu_alu (
    input  logic              alu_valid,
    input  cpu_pkg::alu_op_e  alu_op,
    input  cpu_pkg::op_size_e alu_size,
    input  cpu_pkg::reg_idx_t alu_dst,
    input  logic              alu_use_imm,
    input  cpu_pkg::data_t    alu_imm,
    input  cpu_pkg::data_t    rd_dst_data,
    input  cpu_pkg::data_t    rd_src_data,
    output logic              wr_en,
    output cpu_pkg::reg_idx_t wr_reg,
    output cpu_pkg::op_size_e wr_size,
    output cpu_pkg::data_t    wr_data
);
    import cpu_pkg::*;

    data_t operand;
    data_t result;

    assign operand = alu_use_imm ? alu_imm : rd_src_data;

    always_comb begin
        case (alu_op)
            ALU_MOVE: result = operand;
            ALU_ADD:  result = rd_dst_data + operand;  // carry out dropped
            default:  result = rd_dst_data;
        endcase
    end

    assign wr_en   = alu_valid && (alu_op != ALU_NOP);
    assign wr_reg  = alu_dst;
    assign wr_size = alu_size;
    assign wr_data = result & size_mask(alu_size);  // wraps inside the width

endmodule

/* logic/cpu_ctrl.sv */
// instruction decoder for the reduced TLCS-900 style set
// one registered alu command per completed instruction
// an illegal opcode parks the FSM in ST_HALT until reset
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  cpu_pkg::byte_t      win_bytes [`CPU_WINDOW_BYTES],
    input  cpu_pkg::win_cnt_t   win_count,
    output cpu_pkg::win_cnt_t   consume,
    output logic                alu_valid,
    output cpu_pkg::alu_op_e    alu_op,
    output cpu_pkg::op_size_e   alu_size,
    output cpu_pkg::reg_idx_t   alu_dst,
    output cpu_pkg::reg_idx_t   alu_src,
    output logic                alu_use_imm,
    output cpu_pkg::data_t      alu_imm,
    output logic                inc_rfp,
    output logic                dec_rfp,
    output logic                illegal
);
    import cpu_pkg::*;

    ctrl_state_e state, nx_state;
    byte_t       b0;
    op_size_e    zz_d;      // size field of the byte at the window head
    alu_op_e     imm_op_d;  // 01 is LD, 10 is ADD
    win_cnt_t    imm_need;

    // opcode fields kept while the rest of the instruction arrives
    alu_op_e     kind_q;
    op_size_e    size_q;
    reg_idx_t    dst_q;

    logic        latch_op, load_cmd, nx_inc, nx_dec, nx_use_imm;
    alu_op_e     nx_op;
    op_size_e    nx_size;
    reg_idx_t    nx_dst, nx_src;
    data_t       nx_imm;

    assign b0       = win_bytes[0];
    assign zz_d     = op_size_e'(b0[5:4]);
    assign imm_op_d = (b0[7:6] == 2'b01) ? ALU_MOVE : ALU_ADD;
    assign imm_need = (size_q == SZ_WORD) ? win_cnt_t'(2) : win_cnt_t'(4);
    assign illegal  = state == ST_HALT;

    always_comb begin
        nx_state   = state;
        consume    = '0;
        latch_op   = 1'b0;
        load_cmd   = 1'b0;
        nx_inc     = 1'b0;
        nx_dec     = 1'b0;
        nx_op      = kind_q;
        nx_size    = size_q;
        nx_dst     = dst_q;
        nx_src     = '0;
        nx_use_imm = 1'b1;
        nx_imm     = '0;
        case (state)
            ST_FETCH: if (win_count != '0) begin
                casez (b0)
                    8'h00: consume = win_cnt_t'(1);  // NOP
                    8'h0c: begin  // INCF
                        consume = win_cnt_t'(1);
                        nx_inc  = 1'b1;
                    end
                    8'h0d: begin  // DECF
                        consume = win_cnt_t'(1);
                        nx_dec  = 1'b1;
                    end
                    8'b01??_0???, 8'b10??_0???: begin  // LD r,# and ADD r,#
                        if (b0[5:4] == 2'd3) begin
                            nx_state = ST_HALT;
                        end else if (zz_d != SZ_BYTE) begin
                            consume  = win_cnt_t'(1);
                            latch_op = 1'b1;
                            nx_state = ST_FILL_IMM;
                        end else if (win_count >= win_cnt_t'(2)) begin
                            consume  = win_cnt_t'(2);  // opcode and byte immediate together
                            load_cmd = 1'b1;
                            nx_op    = imm_op_d;
                            nx_size  = SZ_BYTE;
                            nx_dst   = b0[2:0];
                            nx_imm   = {24'd0, win_bytes[1]};
                        end
                    end
                    8'b11??_0???: begin  // register form, second byte decides
                        if (b0[5:4] == 2'd3) begin
                            nx_state = ST_HALT;
                        end else begin
                            consume  = win_cnt_t'(1);
                            latch_op = 1'b1;
                            nx_state = ST_SECOND;
                        end
                    end
                    default: nx_state = ST_HALT;
                endcase
            end
            ST_SECOND: if (win_count != '0) begin
                if (b0[7:4] == 4'h0) begin
                    consume    = win_cnt_t'(1);
                    load_cmd   = 1'b1;
                    nx_op      = b0[3] ? ALU_MOVE : ALU_ADD;
                    nx_src     = b0[2:0];
                    nx_use_imm = 1'b0;
                    nx_state   = ST_FETCH;
                end else begin
                    nx_state = ST_HALT;
                end
            end
            ST_FILL_IMM: if (win_count >= imm_need) begin
                consume  = imm_need;
                load_cmd = 1'b1;
                nx_state = ST_FETCH;
                if (size_q == SZ_WORD)
                    nx_imm = {16'd0, win_bytes[1], win_bytes[0]};
                else
                    nx_imm = {win_bytes[3], win_bytes[2], win_bytes[1], win_bytes[0]};
            end
            default: ;  // halted, nothing consumed
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_FETCH;
            alu_valid <= 1'b0;
            inc_rfp   <= 1'b0;
            dec_rfp   <= 1'b0;
        end else begin
            state     <= nx_state;
            alu_valid <= load_cmd;
            inc_rfp   <= nx_inc;
            dec_rfp   <= nx_dec;
        end
    end

    always_ff @(posedge clk) begin
        if (latch_op) begin
            kind_q <= imm_op_d;
            size_q <= zz_d;
            dst_q  <= b0[2:0];
        end
        if (load_cmd) begin
            alu_op      <= nx_op;
            alu_size    <= nx_size;
            alu_dst     <= nx_dst;
            alu_src     <= nx_src;
            alu_use_imm <= nx_use_imm;
            alu_imm     <= nx_imm;
        end
    end

endmodule

/* logic/cpu_pkg.sv */
// shared types for the core
// op_size_e values equal the zz field of the opcode, zz of 3 is illegal
package cpu_pkg;

    typedef logic [7:0]  byte_t;     // instruction or data byte
    typedef logic [31:0] data_t;     // register and alu value
    typedef logic [23:0] addr_t;     // program address
    typedef logic [2:0]  reg_idx_t;  // register inside a bank
    typedef logic [1:0]  bank_t;     // register file pointer
    typedef logic [2:0]  win_cnt_t;  // window bytes, 0 to 4

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2
    } op_size_e;

    typedef enum logic [1:0] {
        ALU_NOP,
        ALU_MOVE,
        ALU_ADD
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_SECOND,
        ST_FILL_IMM,
        ST_HALT
    } ctrl_state_e;

    // bits of a register that a write of this size touches
    function automatic data_t size_mask(op_size_e size);
        case (size)
            SZ_BYTE: return 32'h0000_00ff;
            SZ_WORD: return 32'h0000_ffff;
            default: return 32'hffff_ffff;
        endcase
    endfunction

endpackage

/* logic/cpu_settings.svh */
// build-time sizes for the core
// the window depth is also the number of fetch credits
// bank count must stay 4, the register file pointer is 2 bits wide
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// instruction window depth in bytes, one credit per slot
`define CPU_WINDOW_BYTES 4

// register file layout
`define CPU_NUM_BANKS 4
`define CPU_NUM_REGS  8

// first program address fetched after reset
`define CPU_RESET_ADDR 24'h00_0000

`endif

/* logic/cpu_top.sv */
// core top level, program memory port and writeback report only
// no data memory, flags or interrupts
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_top (
    input  logic              clk,
    input  logic              rst,
    output logic              req_valid,
    output cpu_pkg::addr_t    req_addr,
    input  logic              rsp_valid,
    input  cpu_pkg::byte_t    rsp_byte,
    output logic              wb_valid,
    output cpu_pkg::bank_t    wb_bank,
    output cpu_pkg::reg_idx_t wb_reg,
    output cpu_pkg::data_t    wb_data,
    output logic              illegal
);
    import cpu_pkg::*;

    byte_t     win_bytes [`CPU_WINDOW_BYTES];
    win_cnt_t  win_count, consume;
    logic      alu_valid, alu_use_imm, inc_rfp, dec_rfp;
    alu_op_e   alu_op;
    op_size_e  alu_size, wr_size;
    reg_idx_t  alu_dst, alu_src, wr_reg;
    data_t     alu_imm, rd_dst_data, rd_src_data, wr_data;
    logic      wr_en;

    op_fetch op_fetch_inst (
        .clk, .rst, .req_valid, .req_addr, .rsp_valid, .rsp_byte,
        .consume, .win_bytes, .win_count
    );

    cpu_ctrl cpu_ctrl_inst (
        .clk, .rst, .win_bytes, .win_count, .consume,
        .alu_valid, .alu_op, .alu_size, .alu_dst, .alu_src, .alu_use_imm, .alu_imm,
        .inc_rfp, .dec_rfp, .illegal
    );

    cpu_alu cpu_alu_inst (
        .alu_valid, .alu_op, .alu_size, .alu_dst, .alu_use_imm, .alu_imm,
        .rd_dst_data, .rd_src_data, .wr_en, .wr_reg, .wr_size, .wr_data
    );

    reg_bank reg_bank_inst (
        .clk, .rst, .inc_rfp, .dec_rfp,
        .rd_dst      (alu_dst),  // reads follow the latched command
        .rd_src      (alu_src),
        .rd_dst_data, .rd_src_data,
        .wr_en, .wr_reg, .wr_size, .wr_data,
        .wb_valid, .wb_bank, .wb_reg, .wb_data
    );

endmodule

/* logic/op_fetch.sv */
// instruction byte window with credit-based program memory requests
// memory must answer every request once, in order, at least a cycle later
// consume must never exceed win_count
`timescale 1ns/1ps
`include "cpu_settings.svh"

module op_fetch (
    input  logic              clk,
    input  logic              rst,
    output logic              req_valid,
    output cpu_pkg::addr_t    req_addr,
    input  logic              rsp_valid,
    input  cpu_pkg::byte_t    rsp_byte,
    input  cpu_pkg::win_cnt_t consume,
    output cpu_pkg::byte_t    win_bytes [`CPU_WINDOW_BYTES],
    output cpu_pkg::win_cnt_t win_count
);
    import cpu_pkg::*;

    byte_t    win_q  [`CPU_WINDOW_BYTES];
    byte_t    win_nx [`CPU_WINDOW_BYTES];
    win_cnt_t filled;       // valid bytes in the window
    win_cnt_t outstanding;  // requested, not yet answered
    win_cnt_t credits;
    win_cnt_t kept;         // bytes left once consume is applied
    logic     issue;
    addr_t    next_addr;

    // a slot is free when neither filled nor already requested
    assign credits   = win_cnt_t'(`CPU_WINDOW_BYTES) - filled - outstanding;
    assign issue     = credits != '0;
    assign kept      = filled - consume;
    assign win_count = filled;
    assign win_bytes = win_q;

    // shift out consumed bytes, then append the new response behind the rest
    always_comb begin
        for (int i = 0; i < `CPU_WINDOW_BYTES; i++) begin
            if (i + int'(consume) < `CPU_WINDOW_BYTES)
                win_nx[i] = win_q[i + int'(consume)];
            else
                win_nx[i] = '0;
            if (rsp_valid && int'(kept) == i)
                win_nx[i] = rsp_byte;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_valid   <= 1'b0;
            filled      <= '0;
            outstanding <= '0;
            next_addr   <= `CPU_RESET_ADDR;
        end else begin
            req_valid   <= issue;  // one request per credit
            filled      <= kept + win_cnt_t'(rsp_valid);
            outstanding <= outstanding + win_cnt_t'(issue) - win_cnt_t'(rsp_valid);
            if (issue)
                next_addr <= next_addr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        win_q <= win_nx;
        if (issue)
            req_addr <= next_addr;
    end

endmodule

/* logic/reg_bank.sv */
// banked register file, the register file pointer picks the bank
// reads are combinational, writes merge only the low 8, 16 or 32 bits
// every write is echoed one cycle later on the wb ports
`timescale 1ns/1ps
`include "cpu_settings.svh"

module reg_bank (
    input  logic              clk,
    input  logic              rst,
    input  logic              inc_rfp,
    input  logic              dec_rfp,
    input  cpu_pkg::reg_idx_t rd_dst,
    input  cpu_pkg::reg_idx_t rd_src,
    output cpu_pkg::data_t    rd_dst_data,
    output cpu_pkg::data_t    rd_src_data,
    input  logic              wr_en,
    input  cpu_pkg::reg_idx_t wr_reg,
    input  cpu_pkg::op_size_e wr_size,
    input  cpu_pkg::data_t    wr_data,
    output logic              wb_valid,
    output cpu_pkg::bank_t    wb_bank,
    output cpu_pkg::reg_idx_t wb_reg,
    output cpu_pkg::data_t    wb_data
);
    import cpu_pkg::*;

    data_t regs [`CPU_NUM_BANKS][`CPU_NUM_REGS];
    bank_t rfp;
    data_t mask;
    data_t merged;  // full register value after the write

    assign rd_dst_data = regs[rfp][rd_dst];
    assign rd_src_data = regs[rfp][rd_src];
    assign mask        = size_mask(wr_size);
    assign merged      = (regs[rfp][wr_reg] & ~mask) | (wr_data & mask);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp      <= '0;
            wb_valid <= 1'b0;
            for (int b = 0; b < `CPU_NUM_BANKS; b++)
                for (int r = 0; r < `CPU_NUM_REGS; r++)
                    regs[b][r] <= '0;
        end else begin
            if (inc_rfp)
                rfp <= rfp + 1'b1;  // wraps modulo 4
            else if (dec_rfp)
                rfp <= rfp - 1'b1;
            if (wr_en)
                regs[rfp][wr_reg] <= merged;
            wb_valid <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            wb_bank <= rfp;
            wb_reg  <= wr_reg;
            wb_data <= merged;
        end
    end

endmodule

/* tb/cpu_assertions.sv */
// protocol checks on the fetch window, memory responses and halt
// attached to cpu_top, window counters taken from op_fetch
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_assertions (
    input logic              clk,
    input logic              rst,
    input cpu_pkg::win_cnt_t filled,
    input cpu_pkg::win_cnt_t outstanding,
    input logic              rsp_valid,
    input logic              wb_valid,
    input logic              illegal
);

    // one credit per window slot
    credit_limit: assert property (@(posedge clk) disable iff (rst)
        (filled + outstanding) <= `CPU_WINDOW_BYTES)
        else $error("window plus outstanding requests above window depth");

    rsp_has_req: assert property (@(posedge clk) disable iff (rst)
        rsp_valid |-> outstanding != '0)
        else $error("response without an outstanding request");

    // a write already in flight may still show in the first halted cycle
    no_wb_halted: assert property (@(posedge clk) disable iff (rst)
        (illegal && $past(illegal)) |-> !wb_valid)
        else $error("writeback while halted");

    illegal_sticky: assert property (@(posedge clk) disable iff (rst)
        illegal |=> illegal)
        else $error("illegal dropped before reset");

endmodule

bind cpu_top cpu_assertions cpu_assertions_inst (
    .clk, .rst,
    .filled      (op_fetch_inst.filled),
    .outstanding (op_fetch_inst.outstanding),
    .rsp_valid, .wb_valid, .illegal
);

/* tb/cpu_tb.sv */
// testbench for cpu_top with a program memory model of random latency
// expected writebacks are worked out by hand from the encoding and write rule
// program space is 256 bytes, the address is taken modulo 256
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    logic     req_valid, wb_valid, illegal;
    logic     rsp_valid = 1'b0;
    byte_t    rsp_byte = '0;
    addr_t    req_addr;
    bank_t    wb_bank;
    reg_idx_t wb_reg;
    data_t    wb_data;

    // program table, one entry per instruction in program order
    string       t_name  [$];
    int          t_len   [$];
    logic [39:0] t_bytes [$];  // first byte in the top bits
    logic        t_wb    [$];
    logic [36:0] t_exp   [$];  // bank, reg, data

    byte_t prog [256];
    int    prog_len = 0;
    addr_t pending [$];  // requests not yet answered
    int    gap = 0;
    int    passes = 0;
    int    fails = 0;

    always #2 clk = ~clk;

    cpu_top cpu_top_inst (
        .clk, .rst, .req_valid, .req_addr, .rsp_valid, .rsp_byte,
        .wb_valid, .wb_bank, .wb_reg, .wb_data, .illegal
    );

    // answers in order, never in the cycle the request shows up
    initial begin : mem_model
        addr_t a;
        void'($urandom(21));  // latency stream starts from a fixed seed
        forever begin
            @(posedge clk);
            rsp_valid <= 1'b0;
            if (pending.size() > 0) begin
                if (gap == 0) begin
                    a = pending.pop_front();
                    rsp_valid <= 1'b1;
                    rsp_byte  <= prog[a[7:0]];
                    gap = $urandom % 4;
                end else begin
                    gap = gap - 1;
                end
            end
            if (req_valid)
                pending.push_back(req_addr);
        end
    end

    task automatic add_test(input string name, input int len, input logic [39:0] bytes,
                            input logic wb, input logic [36:0] exp);
        t_name.push_back(name);
        t_len.push_back(len);
        t_bytes.push_back(bytes);
        t_wb.push_back(wb);
        t_exp.push_back(exp);
        for (int k = 0; k < len; k++) begin
            prog[prog_len] = bytes[39 - 8 * k -: 8];
            prog_len++;
        end
    endtask

    // outputs are sampled on the falling edge
    task automatic wait_wb(output logic seen);
        seen = 1'b0;
        for (int c = 0; c < 200 && !seen; c++) begin
            @(negedge clk);
            seen = wb_valid;
        end
    endtask

    initial begin
        logic        seen;
        logic        quiet;
        logic [36:0] got;
        for (int i = 0; i < 256; i++)
            prog[i] = 8'hff ^ byte_t'(i);  // unused space
        add_test("ld_b_r0",       2, 40'h40_12_00_00_00, 1'b1, {2'd0, 3'd0, 32'h0000_0012});
        add_test("ld_w_r1",       3, 40'h51_56_34_00_00, 1'b1, {2'd0, 3'd1, 32'h0000_3456});
        add_test("ld_l_r2",       5, 40'h62_ef_cd_ab_89, 1'b1, {2'd0, 3'd2, 32'h89ab_cdef});
        add_test("ld_b_r2_low",   2, 40'h42_01_00_00_00, 1'b1, {2'd0, 3'd2, 32'h89ab_cd01});
        add_test("ld_w_r2_low",   3, 40'h52_88_77_00_00, 1'b1, {2'd0, 3'd2, 32'h89ab_7788});
        add_test("add_b_wrap",    2, 40'h82_80_00_00_00, 1'b1, {2'd0, 3'd2, 32'h89ab_7708});
        add_test("add_w_wrap",    3, 40'h92_00_90_00_00, 1'b1, {2'd0, 3'd2, 32'h89ab_0708});
        add_test("add_l_wrap",    5, 40'ha0_f0_ff_ff_ff, 1'b1, {2'd0, 3'd0, 32'h0000_0002});
        add_test("nop",           1, 40'h00_00_00_00_00, 1'b0, '0);
        add_test("ld_rs_b",       2, 40'hc3_0a_00_00_00, 1'b1, {2'd0, 3'd3, 32'h0000_0008});
        add_test("ld_rs_l",       2, 40'he4_0a_00_00_00, 1'b1, {2'd0, 3'd4, 32'h89ab_0708});
        add_test("add_rs_w",      2, 40'hd4_01_00_00_00, 1'b1, {2'd0, 3'd4, 32'h89ab_3b5e});
        add_test("add_rs_l_wrap", 2, 40'he2_04_00_00_00, 1'b1, {2'd0, 3'd2, 32'h1356_4266});
        add_test("incf",          1, 40'h0c_00_00_00_00, 1'b0, '0);
        add_test("bank1_ld",      2, 40'h40_5a_00_00_00, 1'b1, {2'd1, 3'd0, 32'h0000_005a});
        add_test("bank1_zero",    2, 40'h82_01_00_00_00, 1'b1, {2'd1, 3'd2, 32'h0000_0001});
        add_test("decf_1",        1, 40'h0d_00_00_00_00, 1'b0, '0);
        add_test("decf_2",        1, 40'h0d_00_00_00_00, 1'b0, '0);
        add_test("bank3_zero",    2, 40'he3_00_00_00_00, 1'b1, {2'd3, 3'd3, 32'h0000_0000});
        add_test("incf_back",     1, 40'h0c_00_00_00_00, 1'b0, '0);
        add_test("bank0_back",    2, 40'h80_01_00_00_00, 1'b1, {2'd0, 3'd0, 32'h0000_0003});
        prog[prog_len] = 8'hff;  // illegal opcode ends the program
        prog[prog_len + 1] = 8'h40;  // LD r0,#77 behind it, must never execute
        prog[prog_len + 2] = 8'h77;

        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int t = 0; t < t_name.size(); t++) begin
            if (!t_wb[t]) begin
                $display("%s: no writeback expected", t_name[t]);
            end else begin
                wait_wb(seen);
                assert (seen) else begin
                    $display("%s: no writeback within 200 cycles", t_name[t]);
                    fails++;
                end
                if (seen) begin
                    got = {wb_bank, wb_reg, wb_data};
                    assert (got == t_exp[t]) begin
                        $display("%s: pass", t_name[t]);
                        passes++;
                    end else begin
                        $display("mismatch %s: expected bank %0d r%0d %h, actual bank %0d r%0d %h",
                                 t_name[t], t_exp[t][36:35], t_exp[t][34:32], t_exp[t][31:0],
                                 got[36:35], got[34:32], got[31:0]);
                        fails++;
                    end
                end
            end
        end

        // halt on the illegal opcode, then a quiet window
        seen = 1'b0;
        for (int c = 0; c < 200 && !seen; c++) begin
            @(negedge clk);
            seen = illegal;
        end
        assert (seen) else begin
            $display("illegal_halt: illegal never went high");
            fails++;
        end
        if (seen) begin
            quiet = 1'b1;
            for (int c = 0; c < 50; c++) begin
                @(negedge clk);
                if (wb_valid)
                    quiet = 1'b0;
            end
            assert (quiet) begin
                $display("illegal_halt: pass");
                passes++;
            end else begin
                $display("illegal_halt: a writeback appeared after the halt");
                fails++;
            end
        end

        $display("tests passed %0d, failed %0d", passes, fails);
        if (fails == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule
